// ==== common/ramDma_defs.svh ====
// Constants of the CI SRAM and DMA block: sizes, operand A select codes, control and status bits
`ifndef RAM_DMA_DEFS_SVH
`define RAM_DMA_DEFS_SVH

// Local SRAM size in words
`define SRAM_DEPTH 512

// Custom instruction number answered by default
`define DEFAULT_CI_ID 8'h0E

// Operation select in operand A bits 12 to 10
`define SEL_SRAM        3'd0
`define SEL_BUS_ADDRESS 3'd1
`define SEL_MEM_ADDRESS 3'd2
`define SEL_BLOCK_SIZE  3'd3
`define SEL_BURST_SIZE  3'd4
`define SEL_CONTROL     3'd5

// Control register start bits
`define CTRL_READ_BIT  0
`define CTRL_WRITE_BIT 1

// Status word returned by a control read
`define STATUS_BUSY_BIT  0
`define STATUS_ERROR_BIT 1

`endif

// ==== common/ramDmaPkg.sv ====
// Shared word, field, bus and state types for the CI SRAM and DMA block, imported by its modules
package ramDmaPkg;

    typedef logic [31:0] word_t;
    typedef logic [8:0]  sramAddress_t;
    typedef logic [9:0]  blockSize_t;
    // Burst length is held as words minus one, as on the bus
    typedef logic [7:0]  burstSize_t;
    typedef logic [2:0]  regSelect_t;

    typedef struct packed {
        word_t addressData;
        logic  endTransaction;
        logic  dataValid;
        logic  busy;
        logic  error;
    } busIn_t;

    typedef struct packed {
        word_t      addressData;
        burstSize_t burstSize;
        logic [3:0] byteEnable;
        logic       readNWrite;
        logic       beginTransaction;
        logic       endTransaction;
        logic       dataValid;
        logic       busy;
        logic       error;
    } busOut_t;

    typedef struct packed {
        word_t        busStartAddress;
        sramAddress_t memoryStartAddress;
        blockSize_t   blockSize;
        burstSize_t   burstSize;
    } dmaConfig_t;

    typedef enum logic [1:0] {DMA_IDLE, DMA_ISSUE, DMA_WAIT} dmaState_e;

    typedef enum logic [2:0] {
        BUS_IDLE,
        BUS_REQUEST,
        BUS_BEGIN,
        BUS_READ_DATA,
        BUS_WRITE_DATA,
        BUS_FINISH
    } busState_e;

endpackage

// ==== src/dualPortSsram.sv ====
// Synchronous dual-port SRAM shared by the CPU port and the DMA port, one-cycle read on both
`timescale 1ns/1ps
`include "ramDma_defs.svh"

module dualPortSsram #(
    parameter int depth = `SRAM_DEPTH
) (
    input  logic                    clock,
    input  logic                    writeEnableA,
    input  ramDmaPkg::sramAddress_t addressA,
    input  ramDmaPkg::word_t        dataInA,
    input  logic                    writeEnableB,
    input  ramDmaPkg::sramAddress_t addressB,
    input  ramDmaPkg::word_t        dataInB,
    output ramDmaPkg::word_t        dataOutA,
    output ramDmaPkg::word_t        dataOutB
);
    import ramDmaPkg::*;

    word_t memory [depth];

    // Port B wins when both ports write the same word in one cycle
    always_ff @(posedge clock) begin
        if (writeEnableA) begin
            memory[addressA] <= dataInA;
        end
        if (writeEnableB) begin
            memory[addressB] <= dataInB;
        end
    end

    // Reads return the old word, so a write shows on the other port a cycle later
    always_ff @(posedge clock) begin
        dataOutA <= memory[addressA];
        dataOutB <= memory[addressB];
    end

endmodule

// ==== dma/dmaController.sv ====
// DMA configuration and status registers; splits a programmed block into bursts for the bus master
`timescale 1ns/1ps
`include "ramDma_defs.svh"

module dmaController (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    regWrite,
    input  logic                    regRead,
    input  ramDmaPkg::regSelect_t   regSelect,
    input  ramDmaPkg::word_t        writeData,
    input  logic                    burstDone,
    input  logic                    burstError,
    output ramDmaPkg::word_t        regData,
    output logic                    burstStart,
    output ramDmaPkg::word_t        burstAddress,
    output ramDmaPkg::sramAddress_t burstMemAddress,
    output ramDmaPkg::burstSize_t   burstLength,
    output logic                    readNWrite
);
    import ramDmaPkg::*;

    dmaConfig_t dmaConfig;
    dmaState_e  state;
    logic       errorFlag;
    logic       busy;
    logic       startRequest;
    blockSize_t remaining;
    blockSize_t fullBurst;
    blockSize_t thisBurst;
    word_t      status;

    assign busy = (state != DMA_IDLE);

    // A start bit only counts while idle
    assign startRequest = regWrite && (regSelect == `SEL_CONTROL) && !busy
                          && (writeData[`CTRL_READ_BIT] || writeData[`CTRL_WRITE_BIT]);

    // Next burst is the smaller of burst size plus one and what is left
    assign fullBurst   = {2'b00, dmaConfig.burstSize} + 10'd1;
    assign thisBurst   = (remaining < fullBurst) ? remaining : fullBurst;
    assign burstLength = burstSize_t'(thisBurst - 10'd1);
    assign burstStart  = (state == DMA_ISSUE) && (remaining != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= DMA_IDLE;
            errorFlag <= 1'b0;
            dmaConfig <= '0;
            remaining <= '0;
        end else begin
            if (regWrite) begin
                case (regSelect)
                    `SEL_BUS_ADDRESS: dmaConfig.busStartAddress <= writeData;
                    `SEL_MEM_ADDRESS: dmaConfig.memoryStartAddress <= writeData[8:0];
                    `SEL_BLOCK_SIZE:  dmaConfig.blockSize <= writeData[9:0];
                    `SEL_BURST_SIZE:  dmaConfig.burstSize <= writeData[7:0];
                    default: ;
                endcase
            end
            case (state)
                DMA_IDLE: begin
                    if (startRequest) begin
                        errorFlag <= 1'b0;
                        remaining <= dmaConfig.blockSize;
                        state     <= DMA_ISSUE;
                    end
                end
                DMA_ISSUE: begin
                    // Empty block or last burst done
                    if (remaining == '0) begin
                        state <= DMA_IDLE;
                    end else begin
                        remaining <= remaining - thisBurst;
                        state     <= DMA_WAIT;
                    end
                end
                DMA_WAIT: begin
                    if (burstDone && burstError) begin
                        errorFlag <= 1'b1;
                        state     <= DMA_IDLE;
                    end else if (burstDone) begin
                        state <= DMA_ISSUE;
                    end
                end
                default: state <= DMA_IDLE;
            endcase
        end
    end

    // Working addresses, advanced as each burst is handed over
    always_ff @(posedge clock) begin
        if (startRequest) begin
            burstAddress    <= dmaConfig.busStartAddress;
            burstMemAddress <= dmaConfig.memoryStartAddress;
            readNWrite      <= writeData[`CTRL_READ_BIT];
        end else if (burstStart) begin
            burstAddress    <= burstAddress + {20'd0, thisBurst, 2'b00};
            burstMemAddress <= burstMemAddress + sramAddress_t'(thisBurst);
        end
    end

    always_comb begin
        status = '0;
        status[`STATUS_BUSY_BIT]  = busy;
        status[`STATUS_ERROR_BIT] = errorFlag;
    end

    // Register readback, zero-extended
    always_ff @(posedge clock) begin
        if (regRead) begin
            case (regSelect)
                `SEL_BUS_ADDRESS: regData <= dmaConfig.busStartAddress;
                `SEL_MEM_ADDRESS: regData <= word_t'(dmaConfig.memoryStartAddress);
                `SEL_BLOCK_SIZE:  regData <= word_t'(dmaConfig.blockSize);
                `SEL_BURST_SIZE:  regData <= word_t'(dmaConfig.burstSize);
                `SEL_CONTROL:     regData <= status;
                default:          regData <= '0;
            endcase
        end
    end

endmodule

// ==== dma/dmaBusMaster.sv ====
// Bus master for the DMA; requests the bus and runs one read or write burst through SRAM port B
`timescale 1ns/1ps

module dmaBusMaster (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    burstStart,
    input  ramDmaPkg::word_t        burstAddress,
    input  ramDmaPkg::sramAddress_t burstMemAddress,
    input  ramDmaPkg::burstSize_t   burstLength,
    input  logic                    readNWrite,
    input  logic                    busGrant,
    input  ramDmaPkg::busIn_t       busIn,
    input  ramDmaPkg::word_t        sramReadData,
    output logic                    busRequest,
    output ramDmaPkg::busOut_t      busOut,
    output logic                    sramWriteEnable,
    output ramDmaPkg::sramAddress_t sramAddress,
    output ramDmaPkg::word_t        sramWriteData,
    output logic                    burstDone,
    output logic                    burstError
);
    import ramDmaPkg::*;

    busState_e    state;
    word_t        address;
    sramAddress_t memAddress;
    burstSize_t   wordsLeft;
    logic         readBurst;
    logic         errorSeen;
    logic         wordAccepted;

    // Busy arrives through the input register, so the slave raises it
    // one cycle ahead of a word it cannot take
    assign wordAccepted = (state == BUS_WRITE_DATA) && !busIn.busy;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= BUS_IDLE;
            errorSeen <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    errorSeen <= 1'b0;
                    if (burstStart) begin
                        state <= BUS_REQUEST;
                    end
                end
                BUS_REQUEST: begin
                    if (busGrant) begin
                        state <= BUS_BEGIN;
                    end
                end
                BUS_BEGIN: state <= readBurst ? BUS_READ_DATA : BUS_WRITE_DATA;
                BUS_READ_DATA: begin
                    if (busIn.error) begin
                        errorSeen <= 1'b1;
                        state     <= BUS_FINISH;
                    end else if (busIn.endTransaction) begin
                        state <= BUS_FINISH;
                    end
                end
                BUS_WRITE_DATA: begin
                    if (busIn.error) begin
                        errorSeen <= 1'b1;
                        state     <= BUS_FINISH;
                    end else if (wordAccepted && (wordsLeft == '0)) begin
                        state <= BUS_FINISH;
                    end
                end
                BUS_FINISH: state <= BUS_IDLE;
                default:    state <= BUS_IDLE;
            endcase
        end
    end

    // Burst parameters, SRAM pointer and word count
    always_ff @(posedge clock) begin
        if ((state == BUS_IDLE) && burstStart) begin
            address    <= burstAddress;
            memAddress <= burstMemAddress;
            wordsLeft  <= burstLength;
            readBurst  <= readNWrite;
        end else if ((state == BUS_READ_DATA) && busIn.dataValid) begin
            memAddress <= memAddress + 1'b1;
        end else if (wordAccepted) begin
            memAddress <= memAddress + 1'b1;
            wordsLeft  <= wordsLeft - 1'b1;
        end
    end

    always_comb begin
        busOut      = '0;
        sramAddress = memAddress;
        case (state)
            BUS_BEGIN: begin
                busOut.addressData      = address;
                busOut.burstSize        = wordsLeft;
                busOut.byteEnable       = 4'hF;
                busOut.readNWrite       = readBurst;
                busOut.beginTransaction = 1'b1;
            end
            BUS_WRITE_DATA: begin
                busOut.addressData = sramReadData;
                busOut.dataValid   = 1'b1;
                // Fetch the next word only once the current one is taken
                if (wordAccepted) begin
                    sramAddress = memAddress + 1'b1;
                end
            end
            BUS_FINISH: busOut.endTransaction = !readBurst && !errorSeen;
            default: ;
        endcase
    end

    assign busRequest = (state == BUS_REQUEST) || (state == BUS_BEGIN)
                        || (state == BUS_READ_DATA) || (state == BUS_WRITE_DATA);

    assign sramWriteEnable = (state == BUS_READ_DATA) && busIn.dataValid;
    assign sramWriteData   = busIn.addressData;

    assign burstDone  = (state == BUS_FINISH);
    assign burstError = burstDone && errorSeen;

endmodule

// ==== src/ramDmaCi.sv ====
// Top level of the CI SRAM and DMA block; attach to the CPU custom-instruction port and the bus
`timescale 1ns/1ps
`include "ramDma_defs.svh"

module ramDmaCi #(
    parameter logic [7:0] customId = `DEFAULT_CI_ID
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  logic [7:0]          ciN,
    input  ramDmaPkg::word_t    valueA,
    input  ramDmaPkg::word_t    valueB,
    input  logic                busGrant,
    input  ramDmaPkg::busIn_t   busIn,
    output logic                done,
    output ramDmaPkg::word_t    result,
    output logic                busRequest,
    output ramDmaPkg::busOut_t  busOut
);
    import ramDmaPkg::*;

    regSelect_t   select;
    logic         isMine;
    logic         validOp;
    logic         sramOp;
    logic         regOp;
    logic         sramWriteA;
    logic         regWrite;
    logic         regRead;
    logic         doneReg;
    logic         sramReadPending;
    logic         regReadPending;
    word_t        sramDataA;
    word_t        sramDataB;
    word_t        regData;
    word_t        sramWriteDataB;
    sramAddress_t sramAddressB;
    logic         sramWriteEnableB;
    busIn_t       busInReg;
    logic         busGrantReg;
    logic         burstStart;
    logic         burstDone;
    logic         burstError;
    logic         burstReadNWrite;
    word_t        burstAddress;
    sramAddress_t burstMemAddress;
    burstSize_t   burstLength;

    // Operand A decode
    assign select  = valueA[12:10];
    assign isMine  = start && (ciN == customId);
    assign validOp = isMine && (valueA[31:13] == '0);
    assign sramOp  = validOp && (select == `SEL_SRAM);
    assign regOp   = validOp && (select >= `SEL_BUS_ADDRESS) && (select <= `SEL_CONTROL);

    assign sramWriteA = sramOp && valueA[9];
    assign regWrite   = regOp && valueA[9];
    assign regRead    = regOp && !valueA[9];

    // Done one cycle after start, remembering where the result comes from
    always_ff @(posedge clock) begin
        if (reset) begin
            doneReg         <= 1'b0;
            sramReadPending <= 1'b0;
            regReadPending  <= 1'b0;
        end else begin
            doneReg         <= isMine;
            sramReadPending <= sramOp && !valueA[9];
            regReadPending  <= regRead;
        end
    end

    assign done = doneReg;

    always_comb begin
        result = '0;
        if (doneReg && sramReadPending) begin
            result = sramDataA;
        end else if (doneReg && regReadPending) begin
            result = regData;
        end
    end

    // Bus inputs and grant pass through one register stage
    always_ff @(posedge clock) begin
        if (reset) begin
            busInReg    <= '0;
            busGrantReg <= 1'b0;
        end else begin
            busInReg    <= busIn;
            busGrantReg <= busGrant;
        end
    end

    dualPortSsram #(
        .depth(`SRAM_DEPTH)
    ) u_sram (
        .clock       (clock),
        .writeEnableA(sramWriteA),
        .addressA    (valueA[8:0]),
        .dataInA     (valueB),
        .writeEnableB(sramWriteEnableB),
        .addressB    (sramAddressB),
        .dataInB     (sramWriteDataB),
        .dataOutA    (sramDataA),
        .dataOutB    (sramDataB)
    );

    dmaController u_dmaController (
        .clock          (clock),
        .reset          (reset),
        .regWrite       (regWrite),
        .regRead        (regRead),
        .regSelect      (select),
        .writeData      (valueB),
        .burstDone      (burstDone),
        .burstError     (burstError),
        .regData        (regData),
        .burstStart     (burstStart),
        .burstAddress   (burstAddress),
        .burstMemAddress(burstMemAddress),
        .burstLength    (burstLength),
        .readNWrite     (burstReadNWrite)
    );

    dmaBusMaster u_dmaBusMaster (
        .clock          (clock),
        .reset          (reset),
        .burstStart     (burstStart),
        .burstAddress   (burstAddress),
        .burstMemAddress(burstMemAddress),
        .burstLength    (burstLength),
        .readNWrite     (burstReadNWrite),
        .busGrant       (busGrantReg),
        .busIn          (busInReg),
        .sramReadData   (sramDataB),
        .busRequest     (busRequest),
        .busOut         (busOut),
        .sramWriteEnable(sramWriteEnableB),
        .sramAddress    (sramAddressB),
        .sramWriteData  (sramWriteDataB),
        .burstDone      (burstDone),
        .burstError     (burstError)
    );

endmodule

// ==== dv/busMemoryModel.sv ====
// Behavioural bus slave memory for the testbench, with random grant delay, random busy and an error address
`timescale 1ns/1ps

module busMemoryModel #(
    parameter logic [31:0] seed = 32'd73193
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                busRequest,
    input  ramDmaPkg::busOut_t  busOut,
    output logic                busGrant,
    output ramDmaPkg::busIn_t   busIn
);
    import ramDmaPkg::*;

    typedef enum logic [1:0] {SLAVE_IDLE, SLAVE_READ, SLAVE_WRITE} slaveState_e;

    word_t       memory [256];
    word_t       errorAddress = '1;
    logic [31:0] randomState = seed;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Word addressed by bits 9 to 2 of a byte address
    function automatic word_t readWord(input word_t address);
        return memory[address[9:2]];
    endfunction

    task automatic writeWord(input word_t address, input word_t data);
        memory[address[9:2]] = data;
    endtask

    task automatic setErrorAddress(input word_t address);
        errorAddress = address;
    endtask

    // Outputs change on the falling edge and reach the DUT through its input register
    initial begin
        slaveState_e state;
        word_t       address;
        int          remaining;
        logic [2:0]  grantDelay;
        busGrant   = 1'b0;
        busIn      = '0;
        state      = SLAVE_IDLE;
        address    = '0;
        remaining  = 0;
        grantDelay = '0;
        forever begin
            @(negedge clock);
            if (reset) begin
                busGrant = 1'b0;
                busIn    = '0;
                state    = SLAVE_IDLE;
            end else begin
                // The DUT takes a word only when the busy it saw last cycle was low
                if ((state == SLAVE_WRITE) && busOut.dataValid && !busIn.busy) begin
                    writeWord(address, busOut.addressData);
                    address = address + 32'd4;
                end
                if ((state == SLAVE_WRITE) && busOut.endTransaction) begin
                    state = SLAVE_IDLE;
                end
                busIn.dataValid      = 1'b0;
                busIn.endTransaction = 1'b0;
                busIn.error          = 1'b0;
                if (state == SLAVE_READ) begin
                    if (remaining == 0) begin
                        busIn.endTransaction = 1'b1;
                        state = SLAVE_IDLE;
                    end else if (address == errorAddress) begin
                        busIn.error = 1'b1;
                        state = SLAVE_IDLE;
                    end else begin
                        busIn.dataValid   = 1'b1;
                        busIn.addressData = readWord(address);
                        address   = address + 32'd4;
                        remaining = remaining - 1;
                    end
                end
                if (busOut.beginTransaction) begin
                    address   = busOut.addressData;
                    remaining = int'(busOut.burstSize) + 1;
                    state     = busOut.readNWrite ? SLAVE_READ : SLAVE_WRITE;
                end
                randomState = xorshift(randomState);
                busIn.busy  = (state == SLAVE_WRITE) && (randomState[1:0] == 2'd0);
                if (!busRequest) begin
                    busGrant   = 1'b0;
                    grantDelay = randomState[5:3];
                end else if (!busGrant) begin
                    if (grantDelay == '0) begin
                        busGrant = 1'b1;
                    end else begin
                        grantDelay = grantDelay - 3'd1;
                    end
                end
            end
        end
    end

endmodule

// ==== dv/ramDmaCi_assertions.sv ====
// Protocol assertions for the CI SRAM and DMA top level, attached by bind from the testbench
`timescale 1ns/1ps
`include "ramDma_defs.svh"

module ramDmaCiAssertions (
    input logic               clock,
    input logic               reset,
    input logic               start,
    input logic [7:0]         ciN,
    input ramDmaPkg::word_t   valueA,
    input logic               done,
    input logic               busRequest,
    input logic               busGrantReg,
    input ramDmaPkg::busIn_t  busInReg,
    input ramDmaPkg::busOut_t busOut
);
    logic controlWritten;

    // Set by the first control write after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            controlWritten <= 1'b0;
        end else if (start && (ciN == `DEFAULT_CI_ID) && (valueA[12:10] == `SEL_CONTROL)
                     && valueA[9]) begin
            controlWritten <= 1'b1;
        end
    end

    beginWhileGranted: assert property (@(posedge clock) disable iff (reset)
        busOut.beginTransaction |-> busGrantReg)
        else $error("beginTransaction without grant");

    dataHeldWhileBusy: assert property (@(posedge clock) disable iff (reset)
        (busOut.dataValid && busInReg.busy) |=> (busOut.dataValid && $stable(busOut.addressData)))
        else $error("write data changed under busy");

    doneAfterStart: assert property (@(posedge clock) disable iff (reset)
        done |-> $past(start && (ciN == `DEFAULT_CI_ID)))
        else $error("done without a matching start");

    noEarlyRequest: assert property (@(posedge clock) disable iff (reset)
        busRequest |-> controlWritten)
        else $error("bus request before any control write");

endmodule

// ==== dv/ramDmaCiTb.sv ====
// Testbench top for the CI SRAM and DMA block; runs the operations listed in the test data file
`timescale 1ns/1ps
`include "ramDma_defs.svh"

module ramDmaCiTb;
    import ramDmaPkg::*;

    localparam int pollLimit = 2000;

    logic    clock;
    logic    reset;
    logic    start;
    logic [7:0] ciN;
    word_t   valueA;
    word_t   valueB;
    logic    busGrant;
    busIn_t  busIn;
    logic    done;
    word_t   result;
    logic    busRequest;
    busOut_t busOut;

    ramDmaCi u_ramDmaCi (
        .clock     (clock),
        .reset     (reset),
        .start     (start),
        .ciN       (ciN),
        .valueA    (valueA),
        .valueB    (valueB),
        .busGrant  (busGrant),
        .busIn     (busIn),
        .done      (done),
        .result    (result),
        .busRequest(busRequest),
        .busOut    (busOut)
    );

    busMemoryModel busMem (
        .clock     (clock),
        .reset     (reset),
        .busRequest(busRequest),
        .busOut    (busOut),
        .busGrant  (busGrant),
        .busIn     (busIn)
    );

    bind ramDmaCi ramDmaCiAssertions u_assertions (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .ciN        (ciN),
        .valueA     (valueA),
        .done       (done),
        .busRequest (busRequest),
        .busGrantReg(busGrantReg),
        .busInReg   (busInReg),
        .busOut     (busOut)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Test failures found");
            $fatal(1, "simulation stopped");
        end
    endtask

    // One-cycle start pulse, then sample done and result in the following cycle
    task automatic issueInstruction(input logic [7:0] number, input word_t a, input word_t b,
                                    output logic gotDone, output word_t gotResult);
        @(negedge clock);
        start  = 1'b1;
        ciN    = number;
        valueA = a;
        valueB = b;
        @(negedge clock);
        start     = 1'b0;
        ciN       = '0;
        valueA    = '0;
        valueB    = '0;
        gotDone   = done;
        gotResult = result;
    endtask

    task automatic runInstruction(input logic [7:0] number, input word_t a, input word_t b,
                                  input word_t expectDone, input word_t expectResult);
        logic  gotDone;
        word_t gotResult;
        issueInstruction(number, a, b, gotDone, gotResult);
        checkValue("done", word_t'(gotDone), expectDone);
        checkValue("result", gotResult, expectResult);
    endtask

    task automatic waitDmaIdle();
        logic  gotDone;
        word_t status;
        int    polls;
        polls = 0;
        do begin
            issueInstruction(`DEFAULT_CI_ID, word_t'({`SEL_CONTROL, 10'd0}), '0, gotDone, status);
            checkValue("done", word_t'(gotDone), 32'd1);
            polls++;
            if (polls > pollLimit) begin
                stopRun("DMA still busy after the poll limit");
            end
        end while (status[`STATUS_BUSY_BIT]);
    endtask

    // No request and no transaction strobes on the bus
    task automatic checkBusQuiet();
        checkValue("busRequest", word_t'(busRequest), '0);
        checkValue("beginTransaction", word_t'(busOut.beginTransaction), '0);
        checkValue("endTransaction", word_t'(busOut.endTransaction), '0);
        checkValue("dataValid", word_t'(busOut.dataValid), '0);
    endtask

    // Word i of a block holds first plus i
    task automatic checkSramBlock(input word_t address, input word_t first, input word_t count);
        for (int i = 0; i < int'(count); i++) begin
            runInstruction(`DEFAULT_CI_ID,
                           word_t'({`SEL_SRAM, 1'b0, sramAddress_t'(address + word_t'(i))}),
                           '0, 32'd1, first + word_t'(i));
        end
    endtask

    task automatic preloadBusBlock(input word_t address, input word_t first, input word_t count);
        for (int i = 0; i < int'(count); i++) begin
            busMem.writeWord(address + word_t'(4 * i), first + word_t'(i));
        end
    endtask

    task automatic checkBusBlock(input word_t address, input word_t first, input word_t count);
        for (int i = 0; i < int'(count); i++) begin
            checkValue("busMemory", busMem.readWord(address + word_t'(4 * i)), first + word_t'(i));
        end
    endtask

    // Fixed output values checked every cycle
    always @(negedge clock) begin
        if (!reset) begin
            checkValue("busOut.busy", word_t'(busOut.busy), '0);
            checkValue("busOut.error", word_t'(busOut.error), '0);
            if (busOut.beginTransaction) begin
                checkValue("busOut.byteEnable", word_t'(busOut.byteEnable), 32'hF);
            end
            if (!done) begin
                checkValue("result", result, '0);
            end
        end
    end

    initial begin
        #5ms;
        stopRun("simulation ran past its time limit");
    end

    initial begin
        int         fd;
        string      line;
        logic [7:0] op;
        word_t      f1;
        word_t      f2;
        word_t      f3;
        word_t      f4;
        word_t      f5;
        reset  = 1'b1;
        start  = 1'b0;
        ciN    = '0;
        valueA = '0;
        valueB = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        fd = $fopen("dv/ramDmaCi_testdata.txt", "r");
        if (fd == 0) begin
            stopRun("could not open the test data file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            op = "#";
            void'($sscanf(line, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5));
            case (op)
                "P": preloadBusBlock(f1, f2, f3);
                "C": checkBusBlock(f1, f2, f3);
                "S": checkSramBlock(f1, f2, f3);
                "E": busMem.setErrorAddress(f1);
                "I": runInstruction(f1[7:0], f2, f3, f4, f5);
                "W": waitDmaIdle();
                "Q": checkBusQuiet();
                default: ;
            endcase
        end
        $fclose(fd);
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== dv/ramDmaCi_testdata.txt ====
# P/C: bus byte address, first word, count (word i = first + i); S: SRAM address, first, count
# I: ciN, valueA, valueB, done, result; E: error address; W: wait DMA idle; Q: no bus request
Q
I 0e 00001400 00000000 1 00000000
I 0e 00000205 cafe0005 1 00000000
I 0e 000003ff 12345678 1 00000000
I 0e 00000200 0badf00d 1 00000000
I 0e 00000005 00000000 1 cafe0005
I 0e 000001ff 00000000 1 12345678
I 0e 00000000 00000000 1 0badf00d
I 0e 00000600 00001000 1 00000000
I 0e 00000400 00000000 1 00001000
I 0e 00000a00 fffffe20 1 00000000
I 0e 00000800 00000000 1 00000020
I 0e 00000e00 fffffc0a 1 00000000
I 0e 00000c00 00000000 1 0000000a
I 0e 00001200 ffffff03 1 00000000
I 0e 00001000 00000000 1 00000003
I 0f 00000005 00000000 0 00000000
I 0e 00001800 00000000 1 00000000
I 0e 00001c00 00000000 1 00000000
I 0e 00002005 00000000 1 00000000
Q
P 00001000 a0000000 0a
I 0e 00001600 00000001 1 00000000
W
S 020 a0000000 0a
I 0e 00000600 00001100 1 00000000
I 0e 00000e00 00000007 1 00000000
I 0e 00001200 00000002 1 00000000
I 0e 00001600 00000002 1 00000000
W
C 00001100 a0000000 07
E 00001108
I 0e 00000a00 00000100 1 00000000
I 0e 00001600 00000001 1 00000000
W
I 0e 00001400 00000000 1 00000002
E ffffffff
I 0e 00001600 00000001 1 00000000
W
I 0e 00001400 00000000 1 00000000
S 100 a0000000 07

// ==== compile.f ====
+incdir+common
common/ramDmaPkg.sv
src/dualPortSsram.sv
dma/dmaController.sv
dma/dmaBusMaster.sv
src/ramDmaCi.sv
dv/busMemoryModel.sv
dv/ramDmaCi_assertions.sv
dv/ramDmaCiTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module ramDmaCiTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failures found" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
    exit 1
fi
exit 0
